/* filelist.f */
verilog/nocPkg.sv
verilog/flitBuffer.sv
verilog/packetTimer.sv
verilog/switchArbiter.sv
verilog/outputStage.sv
verilog/routerOutputPort.sv
verification/routerOutput_sva.sv
verification/routerTb.sv

/* Makefile */
LOG := sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module routerTb -f filelist.f -o routerSim
	./obj_dir/routerSim | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* verification/routerTb.sv */
module routerTb;
  import nocPkg::*;

  localparam int StepLimit = 500;

  logic                clk;
  logic                rst;
  logic [NumPorts-1:0] inValid;
  flitT [NumPorts-1:0] inFlit;
  logic                outValid;
  flitT                outFlit;
  portIdxT             outPort;

  flitT        sendQ [NumPorts][$];
  flitT        expQ [NumPorts][$];
  portIdxT     headerOrder [$];
  portIdxT     wantOrder [$];
  int          written [NumPorts];
  int          received [NumPorts];
  int          totalIn;
  int          totalOut;
  logic        inPacket;
  portIdxT     curPort;
  logic [15:0] lfsrState;

  routerOutputPort dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  always #2 clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compareFlit(input string name, input flitT got, input flitT want);
    if (got !== want)
      abortRun($sformatf("mismatch %s: got 0x%05h expected 0x%05h", name, got, want));
  endtask

  task automatic comparePort(input string name, input portIdxT got, input portIdxT want);
    if (got !== want)
      abortRun($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
  endtask

  task automatic compareCount(input string name, input int got, input int want);
    if (got != want)
      abortRun($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
  endtask

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic randomBits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[14:0], lfsrState[0]};
    end
  endtask

  // Flit pos of a packet of length len; the header carries the length in its low 12 bits
  function automatic flitT refFlit(input packetLenT len, input int pos, input payloadT rnd);
    flitT f;
    f.payload = rnd;
    f.id = (pos == int'(len) - 1) ? FlitTail : FlitBody;
    if (pos == 0)
    begin
      f.id = FlitHeader;
      f.payload[11:0] = len;
    end
    return f;
  endfunction

  // Waits until the port is free and its buffer has room, so no buffer ever overflows
  task automatic queuePacket(input portIdxT port, input packetLenT len);
    logic [15:0] rnd;
    flitT        f;
    int          waited;
    waited = 0;
    while (sendQ[port].size() != 0 || written[port] - received[port] + int'(len) > BufferDepth)
    begin
      if (waited == StepLimit)
        abortRun($sformatf("port %0d never had room for a new packet", port));
      waited++;
      @(posedge clk);
    end
    for (int pos = 0; pos < int'(len); pos++)
    begin
      randomBits(16, rnd);
      f = refFlit(len, pos, rnd);
      sendQ[port].push_back(f);
      expQ[port].push_back(f);
    end
  endtask

  function automatic logic allDrained();
    for (int p = 0; p < NumPorts; p++)
      if (sendQ[p].size() != 0 || expQ[p].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  task automatic waitDrain();
    int waited;
    waited = 0;
    while (!allDrained())
    begin
      if (waited == StepLimit)
        abortRun("expected flits never left the router");
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic waitHeaders(input int n);
    int waited;
    waited = 0;
    while (headerOrder.size() < n)
    begin
      if (waited == StepLimit)
        abortRun($sformatf("only %0d packet headers arrived", headerOrder.size()));
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic checkOrder();
    compareCount("headers seen", headerOrder.size(), wantOrder.size());
    foreach (wantOrder[i])
      comparePort("outPort order", headerOrder[i], wantOrder[i]);
  endtask

  always @(posedge clk)
  begin
    #1;
    for (int p = 0; p < NumPorts; p++)
    begin
      inValid[p] = sendQ[p].size() != 0;
      inFlit[p] = '0;
      if (inValid[p])
      begin
        inFlit[p] = sendQ[p].pop_front();
        written[p]++;
        totalIn++;
      end
    end
  end

  always @(negedge clk)
  begin : monitorBlock
    flitT want;
    if (!rst && outValid)
    begin
      if (outPort >= NumPorts)
        abortRun($sformatf("output port index %0d is out of range", outPort));
      if (expQ[outPort].size() == 0)
        abortRun($sformatf("flit from port %0d arrived with none expected", outPort));
      // No flit of another port may land inside a packet
      if (inPacket)
        comparePort("outPort", outPort, curPort);
      want = expQ[outPort].pop_front();
      compareFlit("outFlit", outFlit, want);
      if (want.id == FlitHeader)
        headerOrder.push_back(outPort);
      inPacket = (want.id != FlitTail);
      curPort = outPort;
      received[outPort]++;
      totalOut++;
    end
  end

  initial
  begin : mainFlow
    logic [15:0] rnd;
    portIdxT     port;
    packetLenT   len;
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    lfsrState = 16'd54;
    totalIn = 0;
    totalOut = 0;
    inPacket = 1'b0;
    curPort = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      written[p] = 0;
      received[p] = 0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    repeat (20)
    begin
      @(negedge clk);
      if (outValid !== 1'b0)
        abortRun("outValid rose with no input written");
    end
    @(posedge clk);

    queuePacket(3'd1, 12'd4);
    waitDrain();

    // Two packets written side by side; the shorter one completes first and wins from idle
    headerOrder.delete();
    queuePacket(3'd2, 12'd5);
    queuePacket(3'd4, 12'd3);
    waitDrain();
    wantOrder = '{3'd4, 3'd2};
    checkOrder();

    headerOrder.delete();
    for (int p = 0; p < NumPorts; p++)
      queuePacket(portIdxT'(p), 12'd3);
    waitHeaders(3);
    queuePacket(3'd0, 12'd3);
    queuePacket(3'd1, 12'd3);
    queuePacket(3'd2, 12'd3);
    waitDrain();
    wantOrder = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd0, 3'd1, 3'd2};
    checkOrder();

    for (int n = 0; n < 200; n++)
    begin
      randomBits(3, rnd);
      port = portIdxT'(rnd % NumPorts);
      randomBits(3, rnd);
      len = packetLenT'(2 + rnd % 5);
      queuePacket(port, len);
    end
    waitDrain();
    repeat (8) @(posedge clk);
    compareCount("totalOut", totalOut, totalIn);

    if (dut.sva.assertFails == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
    begin
      abortRun($sformatf("%0d assertion failures were reported", dut.sva.assertFails));
    end
  end

endmodule

/* verification/routerOutput_sva.sv */
module routerOutput_sva (
  input logic                        clk,
  input logic                        rst,
  input logic [nocPkg::NumPorts-1:0] inValid,
  input logic [nocPkg::NumPorts-1:0] bufFull,
  input logic [nocPkg::NumPorts-1:0] bufEmpty,
  input logic [nocPkg::NumPorts-1:0] pop,
  input logic                        outValid,
  input nocPkg::flitT                outFlit,
  input nocPkg::portIdxT             outPort
);
  import nocPkg::*;

  int assertFails = 0;

  noOverflow: assert property (@(posedge clk) disable iff (rst) (inValid & bufFull) == '0)
  else
  begin
    assertFails++;
    $error("flit written into a full input buffer");
  end

  // The packet timer must stop popping before the granted buffer runs dry
  popNotEmpty: assert property (@(posedge clk) disable iff (rst) (pop & bufEmpty) == '0)
  else
  begin
    assertFails++;
    $error("pop issued to an empty input buffer");
  end

  // Body and tail flits follow straight on from the port that sent the header
  packetWhole: assert property (@(posedge clk) disable iff (rst)
    outValid && outFlit.id != FlitHeader |-> $past(outValid) && outPort == $past(outPort))
  else
  begin
    assertFails++;
    $error("packet split on the output");
  end

endmodule

bind routerOutputPort routerOutput_sva sva (
  .clk      (clk),
  .rst      (rst),
  .inValid  (inValid),
  .bufFull  (bufFull),
  .bufEmpty (bufEmpty),
  .pop      (pop),
  .outValid (outValid),
  .outFlit  (outFlit),
  .outPort  (outPort)
);

/* verilog/routerOutputPort.sv */
module routerOutputPort (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [nocPkg::NumPorts-1:0]         inValid,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0] inFlit,
  output logic                                outValid,
  output nocPkg::flitT                        outFlit,
  output nocPkg::portIdxT                     outPort
);
  import nocPkg::*;

  flitT [NumPorts-1:0] headFlit;
  logic [NumPorts-1:0] bufEmpty;
  logic [NumPorts-1:0] bufFull;
  logic [NumPorts-1:0] packetReady;
  logic [NumPorts-1:0] pop;
  logic [NumPorts-1:0] grant;

  for (genvar p = 0; p < NumPorts; p++)
  begin : gBuffer
    flitBuffer bufferInst (
      .clk         (clk),
      .rst         (rst),
      .inValid     (inValid[p]),
      .inFlit      (inFlit[p]),
      .pop         (pop[p]),
      .headFlit    (headFlit[p]),
      .empty       (bufEmpty[p]),
      .full        (bufFull[p]),
      .packetReady (packetReady[p])
    );
  end

  switchArbiter arbiterInst (
    .clk         (clk),
    .rst         (rst),
    .headFlit    (headFlit),
    .packetReady (packetReady),
    .pop         (pop),
    .grant       (grant)
  );

  outputStage outInst (
    .clk      (clk),
    .rst      (rst),
    .headFlit (headFlit),
    .grant    (grant),
    .pop      (pop),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

/* verilog/outputStage.sv */
module outputStage (
  input  logic                                clk,
  input  logic                                rst,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0] headFlit,
  input  logic [nocPkg::NumPorts-1:0]         grant,
  input  logic [nocPkg::NumPorts-1:0]         pop,
  output logic                                outValid,
  output nocPkg::flitT                        outFlit,
  output nocPkg::portIdxT                     outPort
);
  import nocPkg::*;

  portIdxT grantIdx;
  flitT    grantFlit;

  // Grant is one-hot so the encoder only has to find the set bit
  always_comb
  begin
    grantIdx = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p])
      begin
        grantIdx = portIdxT'(p);
      end
    end
  end

  assign grantFlit = headFlit[grantIdx];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= grantFlit;
      outPort <= grantIdx;
    end
  end

endmodule

/* verilog/switchArbiter.sv */
module switchArbiter (
  input  logic                                  clk,
  input  logic                                  rst,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0]   headFlit,
  input  logic [nocPkg::NumPorts-1:0]           packetReady,
  output logic [nocPkg::NumPorts-1:0]           pop,
  output logic [nocPkg::NumPorts-1:0]           grant
);
  import nocPkg::*;

  arbStateT            state;
  arbStateT            stateNext;
  logic                granted;
  portIdxT             grantIdx;
  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] timesUp;

  // First requesting port in rotation order beginning at start
  function automatic arbStateT pickNext(input portIdxT start, input logic [NumPorts-1:0] req);
    portIdxT  idx;
    arbStateT pick;
    pick = arbIdle;
    for (int k = NumPorts - 1; k >= 0; k--)
    begin
      idx = portIdxT'((start + k) % NumPorts);
      if (req[idx])
      begin
        pick = arbStateT'(idx + 1);
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    packetTimer timerInst (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  assign granted  = (state != arbIdle);
  assign grantIdx = portIdxT'(state) - 3'd1;
  assign pop      = runTimer;

  always_comb
  begin
    for (int p = 0; p < NumPorts; p++)
    begin
      grant[p] = granted && (grantIdx == portIdxT'(p));
    end
  end

  always_comb
  begin
    stateNext = state;
    runTimer  = '0;
    if (!granted)
    begin
      stateNext = pickNext(portIdxT'(0), packetReady);
    end
    else if (!timesUp[grantIdx])
    begin
      runTimer[grantIdx] = 1'b1;
    end
    else
    begin
      // Packet done, so the search resumes after the port just served
      stateNext = pickNext(grantIdx + 3'd1, packetReady);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbIdle;
    end
    else
    begin
      state <= stateNext;
    end
  end

endmodule

/* verilog/packetTimer.sv */
module packetTimer (
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT headFlit,
  input  logic         runTimer,
  output logic         timesUp
);
  import nocPkg::*;

  packetLenT lenLatched;
  packetLenT count;

  assign timesUp = (count == lenLatched);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenLatched <= '0;
      count      <= '0;
    end
    else
    begin
      // The header sits at the head at least one cycle before its grant starts
      if (headFlit.id == FlitHeader)
      begin
        lenLatched <= headFlit.payload[$bits(packetLenT)-1:0];
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

endmodule

/* verilog/flitBuffer.sv */
module flitBuffer (
  input  logic         clk,
  input  logic         rst,
  input  logic         inValid,
  input  nocPkg::flitT inFlit,
  input  logic         pop,
  output nocPkg::flitT headFlit,
  output logic         empty,
  output logic         full,
  output logic         packetReady
);
  import nocPkg::*;

  flitT                           mem [BufferDepth];
  logic [$clog2(BufferDepth)-1:0] wrPtr;
  logic [$clog2(BufferDepth)-1:0] rdPtr;
  logic [$clog2(BufferDepth):0]   fillCount;
  logic [$clog2(BufferDepth):0]   tailCount;
  logic                           doPop;
  logic                           tailIn;
  logic                           tailOut;

  assign empty       = (fillCount == 0);
  assign full        = (fillCount == BufferDepth);
  assign packetReady = (tailCount != 0);

  // An empty buffer shows an all-zero flit so no timer latches stale memory
  assign headFlit = empty ? '0 : mem[rdPtr];

  assign doPop   = pop && !empty;
  assign tailIn  = inValid && (inFlit.id == FlitTail);
  assign tailOut = doPop && (headFlit.id == FlitTail);

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
      tailCount <= '0;
    end
    else
    begin
      if (inValid)
      begin
        wrPtr <= (wrPtr == BufferDepth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= (rdPtr == BufferDepth - 1) ? '0 : rdPtr + 1'b1;
      end
      if (inValid && !doPop)
      begin
        fillCount <= fillCount + 1'b1;
      end
      else if (!inValid && doPop)
      begin
        fillCount <= fillCount - 1'b1;
      end
      // A packet is complete once its tail is stored
      if (tailIn && !tailOut)
      begin
        tailCount <= tailCount + 1'b1;
      end
      else if (!tailIn && tailOut)
      begin
        tailCount <= tailCount - 1'b1;
      end
    end
  end

endmodule

/* verilog/nocPkg.sv */
package nocPkg;

  localparam int NumPorts = 5;

  localparam int BufferDepth = 16;

  // Port order is Local, North, East, West, South
  typedef logic [2:0] portIdxT;

  typedef logic [2:0] flitIdT;

  // Length counts every flit of the packet including its header
  typedef logic [11:0] packetLenT;

  typedef logic [15:0] payloadT;

  localparam flitIdT FlitHeader = 3'd1;
  localparam flitIdT FlitBody   = 3'd2;
  localparam flitIdT FlitTail   = 3'd3;

  typedef struct packed {
    flitIdT  id;
    payloadT payload;
  } flitT;

  // Grant states follow the port order so a grant state is its port index plus one
  typedef enum logic [2:0] {
    arbIdle,
    arbGrantL,
    arbGrantN,
    arbGrantE,
    arbGrantW,
    arbGrantS
  } arbStateT;

endpackage
